//--- tb.f
+incdir+source
source/axi_noc_pkg.sv
source/ot_fifo.sv
source/vc_rd_if.sv
source/vc_rx_buffers.sv
source/axi_wr_ctrl.sv
source/axi_rd_ctrl.sv
source/axi_noc_slave.sv
tests/axi_noc_checker.sv
tests/tb_axi_noc_slave.sv

//--- Makefile
# Verilator simulation of the AXI to NoC slave

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_axi_noc_slave -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_axi_noc_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

module tb_axi_noc_slave
  import axi_noc_pkg::*;
();
  localparam int TIMEOUT = 200;
  // handshake selectors
  localparam int CH_AW   = 0;
  localparam int CH_W    = 1;
  localparam int CH_AR   = 2;
  localparam int CH_PKT  = 3;

  logic                       clk_axi;
  logic                       arst_axi;
  logic                       awvalid_i;
  logic                       awready_o;
  logic [`AXI_NOC_ADDR_W-1:0] awaddr_i;
  logic [`AXI_NOC_ID_W-1:0]   awid_i;
  logic [7:0]                 awlen_i;
  logic [2:0]                 awsize_i;
  logic [1:0]                 awburst_i;
  logic                       wvalid_i;
  logic                       wready_o;
  flit_t                      wdata_i;
  logic                       wlast_i;
  logic                       bvalid_o;
  logic                       bready_i;
  logic [`AXI_NOC_ID_W-1:0]   bid_o;
  logic [1:0]                 bresp_o;
  logic                       arvalid_i;
  logic                       arready_o;
  logic [`AXI_NOC_ADDR_W-1:0] araddr_i;
  logic [`AXI_NOC_ID_W-1:0]   arid_i;
  logic [7:0]                 arlen_i;
  logic [2:0]                 arsize_i;
  logic [1:0]                 arburst_i;
  logic                       rvalid_o;
  logic                       rready_i;
  flit_t                      rdata_o;
  logic [`AXI_NOC_ID_W-1:0]   rid_o;
  logic [1:0]                 rresp_o;
  logic                       rlast_o;
  logic                       pkt_out_valid_o;
  vc_id_t                     pkt_out_vc_o;
  flit_t                      pkt_out_data_o;
  logic                       pkt_out_ready_i;
  logic                       pkt_in_valid_i;
  vc_id_t                     pkt_in_vc_i;
  flit_t                      pkt_in_data_i;
  logic                       pkt_in_ready_o;

  integer      seed = 32'h0e7995cf;
  logic [31:0] rnd;
  logic        stall_en = 1'b0;
  int          timeouts = 0;
  int          err_mark = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          i;
  // flits injected and not yet claimed by a read
  flit_t       rx_model [`AXI_NOC_NUM_VC][$];

  axi_noc_slave axi_noc_slave_i (.*);

  axi_noc_checker u_checker (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .pkt_out_valid_i (pkt_out_valid_o),
    .pkt_out_ready_i (pkt_out_ready_i),
    .pkt_out_vc_i    (pkt_out_vc_o),
    .pkt_out_data_i  (pkt_out_data_o),
    .bvalid_i        (bvalid_o),
    .bready_i        (bready_i),
    .bid_i           (bid_o),
    .bresp_i         (bresp_o),
    .rvalid_i        (rvalid_o),
    .rready_i        (rready_i),
    .rdata_i         (rdata_o),
    .rid_i           (rid_o),
    .rresp_i         (rresp_o),
    .rlast_i         (rlast_o)
  );

  initial begin
    clk_axi = 1'b0;
    forever #20 clk_axi = ~clk_axi;
  end

  // ready stalls on the sink side, about one cycle in four
  initial begin
    rready_i        = 1'b1;
    bready_i        = 1'b1;
    pkt_out_ready_i = 1'b1;
    forever begin
      @(posedge clk_axi);
      #2;
      rnd             = stall_en ? $random(seed) : 32'hffff_ffff;
      rready_i        = |rnd[1:0];
      bready_i        = |rnd[3:2];
      pkt_out_ready_i = |rnd[5:4];
    end
  end

  // ************************************************************
  // reference model of the address check
  // ************************************************************
  // channel number for a valid request, -1 for an error request
  function automatic int ref_vc(input logic [15:0] addr, input logic [15:0] base,
                                input logic [1:0] burst, input logic [2:0] size,
                                input logic [`AXI_NOC_NUM_VC-1:0] vc_empty);
    int offs;
    int slot;
    offs = int'(addr) - int'(base);
    slot = offs / 8;
    if (burst != 2'b01 || size != 3'd2) return -1;
    if (offs < 0 || offs % 8 != 0 || slot >= `AXI_NOC_NUM_VC) return -1;
    if (vc_empty[slot]) return -1;
    return slot;
  endfunction

  function automatic logic ready_of(input int ch);
    case (ch)
      CH_AW:   return awready_o;
      CH_W:    return wready_o;
      CH_AR:   return arready_o;
      default: return pkt_in_ready_o;
    endcase
  endfunction

  // valid is already up; returns 2 ns after the transfer edge
  task automatic await_transfer(input int ch, input string what);
    int n;
    n = 0;
    @(negedge clk_axi);
    while (!ready_of(ch) && n < TIMEOUT) begin
      @(negedge clk_axi);
      n++;
    end
    if (!ready_of(ch)) begin
      timeouts++;
      $display("timeout: the %s handshake did not complete by %0t", what, $time);
    end
    @(posedge clk_axi);
    #2;
  endtask

  task automatic write_burst(input logic [15:0] addr, input logic [3:0] id,
                             input logic [7:0] len, input logic [2:0] size,
                             input logic [1:0] burst);
    int    vc;
    int    k;
    flit_t beat [$];
    vc = ref_vc(addr, `AXI_NOC_WR_BASE, burst, size, '0);
    for (k = 0; k <= int'(len); k++) begin
      beat.push_back($random(seed));
      if (vc >= 0) u_checker.expect_flit(vc_id_t'(vc), beat[k]);
    end
    u_checker.expect_resp(id, (vc < 0) ? 2'b10 : 2'b00);
    fork
      begin
        awvalid_i = 1'b1;
        awaddr_i  = addr;
        awid_i    = id;
        awlen_i   = len;
        awsize_i  = size;
        awburst_i = burst;
        await_transfer(CH_AW, "write address");
        awvalid_i = 1'b0;
      end
      begin
        for (k = 0; k <= int'(len); k++) begin
          wvalid_i = 1'b1;
          wdata_i  = beat[k];
          wlast_i  = (k == int'(len));
          await_transfer(CH_W, "write data");
        end
        wvalid_i = 1'b0;
        wlast_i  = 1'b0;
      end
    join
  endtask

  // empty state seen by the model must match the DUT at acceptance
  task automatic read_burst(input logic [15:0] addr, input logic [3:0] id,
                            input logic [7:0] len, input logic [2:0] size,
                            input logic [1:0] burst);
    logic [`AXI_NOC_NUM_VC-1:0] empty_now;
    int                         vc;
    int                         k;
    for (k = 0; k < `AXI_NOC_NUM_VC; k++) empty_now[k] = (rx_model[k].size() == 0);
    vc = ref_vc(addr, `AXI_NOC_RD_BASE, burst, size, empty_now);
    if (vc < 0) begin
      u_checker.expect_read('0, id, 2'b10, 1'b1);
    end else begin
      for (k = 0; k <= int'(len); k++) begin
        u_checker.expect_read(rx_model[vc].pop_front(), id, 2'b00, k == int'(len));
      end
    end
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arid_i    = id;
    arlen_i   = len;
    arsize_i  = size;
    arburst_i = burst;
    await_transfer(CH_AR, "read address");
    arvalid_i = 1'b0;
  endtask

  task automatic inject_flit(input int vc, input flit_t data);
    pkt_in_valid_i = 1'b1;
    pkt_in_vc_i    = vc_id_t'(vc);
    pkt_in_data_i  = data;
    await_transfer(CH_PKT, "packet input");
    pkt_in_valid_i = 1'b0;
    rx_model[vc].push_back(data);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (u_checker.pending() != 0 && n < 4 * TIMEOUT) begin
      @(negedge clk_axi);
      n++;
    end
    if (u_checker.pending() != 0) begin
      timeouts++;
      $display("timeout: %0d expected transfers never arrived", u_checker.pending());
    end
    @(posedge clk_axi);
    #2;
  endtask

  // one line per test
  task automatic close_test(input string name);
    int bad;
    wait_idle();
    bad = u_checker.errors + timeouts;
    if (bad == err_mark) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: not ok, %0d problems", name, bad - err_mark);
    end
    err_mark = bad;
  endtask

  // ************************************************************
  // test sequence
  // ************************************************************
  initial begin
    arst_axi       = 1'b1;
    awvalid_i      = 1'b0;
    awaddr_i       = '0;
    awid_i         = '0;
    awlen_i        = '0;
    awsize_i       = '0;
    awburst_i      = '0;
    wvalid_i       = 1'b0;
    wdata_i        = '0;
    wlast_i        = 1'b0;
    arvalid_i      = 1'b0;
    araddr_i       = '0;
    arid_i         = '0;
    arlen_i        = '0;
    arsize_i       = '0;
    arburst_i      = '0;
    pkt_in_valid_i = 1'b0;
    pkt_in_vc_i    = '0;
    pkt_in_data_i  = '0;
    repeat (16) @(posedge clk_axi);
    #2;
    arst_axi = 1'b0;

    // idle levels out of reset
    @(negedge clk_axi);
    u_checker.check_level("awready_o", awready_o, 1'b1);
    u_checker.check_level("arready_o", arready_o, 1'b1);
    u_checker.check_level("bvalid_o", bvalid_o, 1'b0);
    u_checker.check_level("rvalid_o", rvalid_o, 1'b0);
    u_checker.check_level("wready_o", wready_o, 1'b0);
    u_checker.check_level("pkt_out_valid_o", pkt_out_valid_o, 1'b0);
    @(posedge clk_axi);
    #2;
    close_test("0 reset levels");

    write_burst(16'h1008, 4'h5, 8'd3, 3'd2, 2'b01);
    close_test("1 incr write to channel 1");

    // fixed burst, narrow size, unmapped address
    write_burst(16'h1000, 4'h1, 8'd1, 3'd2, 2'b00);
    write_burst(16'h1000, 4'h2, 8'd0, 3'd1, 2'b01);
    write_burst(16'h3000, 4'h3, 8'd2, 3'd2, 2'b01);
    close_test("2 error writes");

    // even flits to channel 0, odd ones to channel 1
    for (i = 0; i < 7; i++) inject_flit(i % 2, 32'hc0de_0000 | (i << 8) | i);
    read_burst(16'h2000, 4'h6, 8'd3, 3'd2, 2'b01);
    read_burst(16'h2008, 4'h7, 8'd2, 3'd2, 2'b01);
    close_test("3 read back per channel");

    read_burst(16'h2008, 4'h8, 8'd3, 3'd2, 2'b01);
    inject_flit(0, 32'h5a5a_0001);
    // flit stays buffered after the bad burst
    read_burst(16'h2000, 4'h9, 8'd0, 3'd2, 2'b00);
    read_burst(16'h2000, 4'ha, 8'd0, 3'd2, 2'b01);
    close_test("4 error reads");

    stall_en = 1'b1;
    for (i = 0; i < `AXI_NOC_RX_DEPTH; i++) inject_flit(0, $random(seed));
    @(negedge clk_axi);
    u_checker.check_level("pkt_in_ready_o", pkt_in_ready_o, 1'b0);
    @(posedge clk_axi);
    #2;
    for (i = 0; i < 3; i++) inject_flit(1, $random(seed));
    write_burst(16'h1000, 4'h1, 8'd2, 3'd2, 2'b01);
    write_burst(16'h1008, 4'h2, 8'd0, 3'd2, 2'b01);
    write_burst(16'h1010, 4'h3, 8'd1, 3'd2, 2'b01);
    write_burst(16'h1008, 4'h4, 8'd7, 3'd2, 2'b01);
    read_burst(16'h2000, 4'h5, 8'd3, 3'd2, 2'b01);
    read_burst(16'h2000, 4'h6, 8'd3, 3'd2, 2'b01);
    read_burst(16'h2008, 4'h7, 8'd2, 3'd2, 2'b01);
    close_test("5 back to back with stalls");
    stall_en = 1'b0;

    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/axi_noc_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

module axi_noc_checker
  import axi_noc_pkg::*;
(
  input  logic                     clk_axi,
  input  logic                     arst_axi,
  // packet output of the DUT
  input  logic                     pkt_out_valid_i,
  input  logic                     pkt_out_ready_i,
  input  vc_id_t                   pkt_out_vc_i,
  input  flit_t                    pkt_out_data_i,
  // write response
  input  logic                     bvalid_i,
  input  logic                     bready_i,
  input  logic [`AXI_NOC_ID_W-1:0] bid_i,
  input  logic [1:0]               bresp_i,
  // read data
  input  logic                     rvalid_i,
  input  logic                     rready_i,
  input  flit_t                    rdata_i,
  input  logic [`AXI_NOC_ID_W-1:0] rid_i,
  input  logic [1:0]               rresp_i,
  input  logic                     rlast_i
);
  typedef struct packed {
    vc_id_t vc;
    flit_t  data;
  } flit_exp_t;

  typedef struct packed {
    logic [`AXI_NOC_ID_W-1:0] id;
    logic [1:0]               resp;
  } b_exp_t;

  typedef struct packed {
    flit_t                    data;
    logic [`AXI_NOC_ID_W-1:0] id;
    logic [1:0]               resp;
    logic                     last;
  } r_exp_t;

  // expected transfers, oldest first
  flit_exp_t exp_flit [$];
  b_exp_t    exp_b [$];
  r_exp_t    exp_r [$];
  flit_exp_t head_flit;
  b_exp_t    head_b;
  r_exp_t    head_r;
  int        errors = 0;

  // ************************************************************
  // filled by the stimulus
  // ************************************************************
  task automatic expect_flit(input vc_id_t vc, input flit_t data);
    flit_exp_t e;
    e.vc   = vc;
    e.data = data;
    exp_flit.push_back(e);
  endtask

  task automatic expect_resp(input logic [`AXI_NOC_ID_W-1:0] id, input logic [1:0] resp);
    b_exp_t e;
    e.id   = id;
    e.resp = resp;
    exp_b.push_back(e);
  endtask

  task automatic expect_read(input flit_t data, input logic [`AXI_NOC_ID_W-1:0] id,
                             input logic [1:0] resp, input logic last);
    r_exp_t e;
    e.data = data;
    e.id   = id;
    e.resp = resp;
    e.last = last;
    exp_r.push_back(e);
  endtask

  // transfers still owed by the DUT
  function automatic int pending();
    return exp_flit.size() + exp_b.size() + exp_r.size();
  endfunction

  task automatic compare_field(input string name, input logic [`AXI_NOC_DATA_W-1:0] got,
                               input logic [`AXI_NOC_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // single level, called for static checks
  task automatic check_level(input string name, input logic got, input logic exp);
    compare_field(name, {{(`AXI_NOC_DATA_W-1){1'b0}}, got}, {{(`AXI_NOC_DATA_W-1){1'b0}}, exp});
  endtask

  // ************************************************************
  // compare at the falling edge
  // ************************************************************
  // valid and ready are settled here, the transfer happens on the next rise
  always @(negedge clk_axi) begin
    if (!arst_axi) begin
      if (pkt_out_valid_i && pkt_out_ready_i) begin
        if (exp_flit.size() == 0) begin
          $display("unexpected flit on pkt_out at %0t with nothing queued", $time);
          errors++;
        end else begin
          head_flit = exp_flit.pop_front();
          compare_field("pkt_out_vc_o", `AXI_NOC_DATA_W'(pkt_out_vc_i),
                        `AXI_NOC_DATA_W'(head_flit.vc));
          compare_field("pkt_out_data_o", pkt_out_data_i, head_flit.data);
        end
      end
      if (bvalid_i && bready_i) begin
        if (exp_b.size() == 0) begin
          $display("unexpected write response at %0t with nothing queued", $time);
          errors++;
        end else begin
          head_b = exp_b.pop_front();
          compare_field("bid_o", `AXI_NOC_DATA_W'(bid_i), `AXI_NOC_DATA_W'(head_b.id));
          compare_field("bresp_o", `AXI_NOC_DATA_W'(bresp_i), `AXI_NOC_DATA_W'(head_b.resp));
        end
      end
      if (rvalid_i && rready_i) begin
        if (exp_r.size() == 0) begin
          $display("unexpected read beat at %0t with nothing queued", $time);
          errors++;
        end else begin
          head_r = exp_r.pop_front();
          compare_field("rdata_o", rdata_i, head_r.data);
          compare_field("rid_o", `AXI_NOC_DATA_W'(rid_i), `AXI_NOC_DATA_W'(head_r.id));
          compare_field("rresp_o", `AXI_NOC_DATA_W'(rresp_i), `AXI_NOC_DATA_W'(head_r.resp));
          check_level("rlast_o", rlast_i, head_r.last);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/axi_noc_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

module axi_noc_slave
  import axi_noc_pkg::*;
(
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // write address
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`AXI_NOC_ADDR_W-1:0] awaddr_i,
  input  logic [`AXI_NOC_ID_W-1:0]   awid_i,
  input  logic [7:0]                 awlen_i,
  input  logic [2:0]                 awsize_i,
  input  logic [1:0]                 awburst_i,
  // write data
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  flit_t                      wdata_i,
  input  logic                       wlast_i,
  // write response
  output logic                       bvalid_o,
  input  logic                       bready_i,
  output logic [`AXI_NOC_ID_W-1:0]   bid_o,
  output logic [1:0]                 bresp_o,
  // read address
  input  logic                       arvalid_i,
  output logic                       arready_o,
  input  logic [`AXI_NOC_ADDR_W-1:0] araddr_i,
  input  logic [`AXI_NOC_ID_W-1:0]   arid_i,
  input  logic [7:0]                 arlen_i,
  input  logic [2:0]                 arsize_i,
  input  logic [1:0]                 arburst_i,
  // read data
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output flit_t                      rdata_o,
  output logic [`AXI_NOC_ID_W-1:0]   rid_o,
  output logic [1:0]                 rresp_o,
  output logic                       rlast_o,
  // towards the router
  output logic                       pkt_out_valid_o,
  output vc_id_t                     pkt_out_vc_o,
  output flit_t                      pkt_out_data_o,
  input  logic                       pkt_out_ready_i,
  // from the router
  input  logic                       pkt_in_valid_i,
  input  vc_id_t                     pkt_in_vc_i,
  input  flit_t                      pkt_in_data_i,
  output logic                       pkt_in_ready_o
);
  // read controller to receive buffers
  vc_rd_if vc_rd ();

  // ************************************************************
  // write path
  // ************************************************************
  axi_wr_ctrl u_wr_ctrl (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .awvalid_i       (awvalid_i),
    .awaddr_i        (awaddr_i),
    .awid_i          (awid_i),
    .awlen_i         (awlen_i),
    .awsize_i        (awsize_i),
    .awburst_i       (awburst_i),
    .awready_o       (awready_o),
    .wvalid_i        (wvalid_i),
    .wdata_i         (wdata_i),
    .wlast_i         (wlast_i),
    .wready_o        (wready_o),
    .bready_i        (bready_i),
    .bvalid_o        (bvalid_o),
    .bid_o           (bid_o),
    .bresp_o         (bresp_o),
    .pkt_out_valid_o (pkt_out_valid_o),
    .pkt_out_vc_o    (pkt_out_vc_o),
    .pkt_out_data_o  (pkt_out_data_o),
    .pkt_out_ready_i (pkt_out_ready_i)
  );

  // ************************************************************
  // read path
  // ************************************************************
  axi_rd_ctrl u_rd_ctrl (
    .clk_axi   (clk_axi),
    .arst_axi  (arst_axi),
    .arvalid_i (arvalid_i),
    .araddr_i  (araddr_i),
    .arid_i    (arid_i),
    .arlen_i   (arlen_i),
    .arsize_i  (arsize_i),
    .arburst_i (arburst_i),
    .arready_o (arready_o),
    .rready_i  (rready_i),
    .rvalid_o  (rvalid_o),
    .rdata_o   (rdata_o),
    .rid_o     (rid_o),
    .rresp_o   (rresp_o),
    .rlast_o   (rlast_o),
    .rd        (vc_rd)
  );

  // per-channel storage of incoming flits
  vc_rx_buffers u_rx_buffers (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .pkt_in_valid_i (pkt_in_valid_i),
    .pkt_in_vc_i    (pkt_in_vc_i),
    .pkt_in_data_i  (pkt_in_data_i),
    .pkt_in_ready_o (pkt_in_ready_o),
    .rd             (vc_rd)
  );

endmodule

`default_nettype wire

//--- source/axi_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

module axi_rd_ctrl
  import axi_noc_pkg::*;
(
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // read address
  input  logic                       arvalid_i,
  input  logic [`AXI_NOC_ADDR_W-1:0] araddr_i,
  input  logic [`AXI_NOC_ID_W-1:0]   arid_i,
  input  logic [7:0]                 arlen_i,
  input  logic [2:0]                 arsize_i,
  input  logic [1:0]                 arburst_i,
  output logic                       arready_o,
  // read data
  input  logic                       rready_i,
  output logic                       rvalid_o,
  output flit_t                      rdata_o,
  output logic [`AXI_NOC_ID_W-1:0]   rid_o,
  output logic [1:0]                 rresp_o,
  output logic                       rlast_o,
  // receive buffers
  vc_rd_if.rd_ctrl                   rd
);
  vc_id_t     ar_vc;
  logic       ar_ok;
  logic       ar_hs;
  ot_entry_t  ar_entry;
  ot_entry_t  rq_head;
  logic       rq_full;
  logic       rq_empty;
  logic       active_q;
  logic [7:0] beat_q;
  logic       r_hs;
  logic       r_done;

  // ************************************************************
  // address check against window and buffer state
  // ************************************************************
  assign arready_o = ~rq_full;
  assign ar_hs     = arvalid_i && arready_o;
  assign ar_vc     = win_vc(araddr_i, `AXI_NOC_RD_BASE);
  // empty channel at acceptance turns into an error
  assign ar_ok     = (arburst_i == BURST_INCR) && (arsize_i == 3'd2) &&
                     win_hit(araddr_i, `AXI_NOC_RD_BASE) && ~rd.empty[ar_vc];

  always_comb begin
    ar_entry.vc    = ar_vc;
    ar_entry.len   = arlen_i;
    ar_entry.id    = arid_i;
    ar_entry.error = ~ar_ok;
  end

  ot_fifo #(
    .item_t (ot_entry_t),
    .DEPTH  (`AXI_NOC_OT_RD)
  ) u_rd_queue (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .push_i      (ar_hs),
    .push_data_i (ar_entry),
    .pop_i       (r_done),
    .head_o      (rq_head),
    .full_o      (rq_full),
    .empty_o     (rq_empty)
  );

  // ************************************************************
  // beat sequencing
  // ************************************************************
  // head channel drives the buffer mux
  assign rd.sel_vc = rq_head.vc;

  // error entry gives a single zero beat
  assign rvalid_o = active_q && (rq_head.error || ~rd.empty[rq_head.vc]);
  assign rlast_o  = rvalid_o && (rq_head.error || (beat_q == rq_head.len));
  assign rdata_o  = rq_head.error ? '0 : rd.head_data;
  assign rid_o    = rq_head.id;
  assign rresp_o  = rq_head.error ? RESP_SLVERR : RESP_OKAY;

  assign r_hs   = rvalid_o && rready_i;
  assign r_done = r_hs && rlast_o;
  // buffer word leaves with each accepted data beat
  assign rd.pop = r_hs && ~rq_head.error;

  // active a cycle after the queue fills, one idle cycle after rlast
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      active_q <= 1'b0;
      beat_q   <= '0;
    end else begin
      if (r_done) begin
        active_q <= 1'b0;
        beat_q   <= '0;
      end else begin
        if (~rq_empty) begin
          active_q <= 1'b1;
        end
        if (r_hs) begin
          beat_q <= beat_q + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/axi_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

module axi_wr_ctrl
  import axi_noc_pkg::*;
(
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // write address
  input  logic                       awvalid_i,
  input  logic [`AXI_NOC_ADDR_W-1:0] awaddr_i,
  input  logic [`AXI_NOC_ID_W-1:0]   awid_i,
  input  logic [7:0]                 awlen_i,
  input  logic [2:0]                 awsize_i,
  input  logic [1:0]                 awburst_i,
  output logic                       awready_o,
  // write data
  input  logic                       wvalid_i,
  input  flit_t                      wdata_i,
  input  logic                       wlast_i,
  output logic                       wready_o,
  // write response
  input  logic                       bready_i,
  output logic                       bvalid_o,
  output logic [`AXI_NOC_ID_W-1:0]   bid_o,
  output logic [1:0]                 bresp_o,
  // packet output
  output logic                       pkt_out_valid_o,
  output vc_id_t                     pkt_out_vc_o,
  output flit_t                      pkt_out_data_o,
  input  logic                       pkt_out_ready_i
);
  logic      aw_ok;
  logic      aw_hs;
  ot_entry_t aw_entry;
  ot_entry_t wq_head;
  logic      wq_full;
  logic      wq_empty;
  logic      w_open;
  logic      w_done;
  wr_resp_t  rsp_in;
  wr_resp_t  rsp_head;
  logic      rsp_full;
  logic      rsp_empty;

  // ************************************************************
  // address check, every handshake queues an entry
  // ************************************************************
  assign awready_o = ~wq_full;
  assign aw_hs     = awvalid_i && awready_o;
  assign aw_ok     = (awburst_i == BURST_INCR) && (awsize_i == 3'd2) &&
                     win_hit(awaddr_i, `AXI_NOC_WR_BASE);

  always_comb begin
    aw_entry.vc    = win_vc(awaddr_i, `AXI_NOC_WR_BASE);
    aw_entry.len   = awlen_i;
    aw_entry.id    = awid_i;
    aw_entry.error = ~aw_ok;
  end

  ot_fifo #(
    .item_t (ot_entry_t),
    .DEPTH  (`AXI_NOC_OT_WR)
  ) u_wr_queue (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .push_i      (aw_hs),
    .push_data_i (aw_entry),
    .pop_i       (w_done),
    .head_o      (wq_head),
    .full_o      (wq_full),
    .empty_o     (wq_empty)
  );

  // ************************************************************
  // data beats
  // ************************************************************
  // burst open and room left for its response
  assign w_open = ~wq_empty && ~rsp_full;

  // error bursts sink their beats
  assign wready_o        = w_open && (wq_head.error || pkt_out_ready_i);
  assign pkt_out_valid_o = w_open && ~wq_head.error && wvalid_i;
  assign pkt_out_vc_o    = wq_head.vc;
  assign pkt_out_data_o  = wdata_i;

  // last beat closes the burst
  assign w_done = wvalid_i && wready_o && wlast_i;

  // ************************************************************
  // responses, in wlast order
  // ************************************************************
  always_comb begin
    rsp_in.id    = wq_head.id;
    rsp_in.error = wq_head.error;
  end

  ot_fifo #(
    .item_t (wr_resp_t),
    .DEPTH  (`AXI_NOC_OT_WR)
  ) u_rsp_queue (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .push_i      (w_done),
    .push_data_i (rsp_in),
    .pop_i       (bvalid_o && bready_i),
    .head_o      (rsp_head),
    .full_o      (rsp_full),
    .empty_o     (rsp_empty)
  );

  assign bvalid_o = ~rsp_empty;
  assign bid_o    = rsp_head.id;
  assign bresp_o  = rsp_head.error ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

//--- source/vc_rx_buffers.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

module vc_rx_buffers
  import axi_noc_pkg::*;
(
  input  logic     clk_axi,
  input  logic     arst_axi,
  input  logic     pkt_in_valid_i,
  input  vc_id_t   pkt_in_vc_i,
  input  flit_t    pkt_in_data_i,
  output logic     pkt_in_ready_o,
  vc_rd_if.buffers rd
);
  logic [`AXI_NOC_NUM_VC-1:0] buf_full;
  logic [`AXI_NOC_NUM_VC-1:0] buf_empty;
  logic [`AXI_NOC_NUM_VC-1:0] buf_push;
  logic [`AXI_NOC_NUM_VC-1:0] buf_pop;
  flit_t                      buf_head [`AXI_NOC_NUM_VC];

  // back-pressure from the addressed buffer only
  assign pkt_in_ready_o = ~buf_full[pkt_in_vc_i];

  // read side sees the selected head
  assign rd.head_data = buf_head[rd.sel_vc];
  assign rd.empty     = buf_empty;

  // ************************************************************
  // one receive buffer per channel
  // ************************************************************
  for (genvar i = 0; i < `AXI_NOC_NUM_VC; i++) begin : gen_vc_buf
    // steer flit by channel tag
    assign buf_push[i] = pkt_in_valid_i && pkt_in_ready_o && (pkt_in_vc_i == vc_id_t'(i));
    assign buf_pop[i]  = rd.pop && (rd.sel_vc == vc_id_t'(i));

    ot_fifo #(
      .item_t (flit_t),
      .DEPTH  (`AXI_NOC_RX_DEPTH)
    ) u_rx_buf (
      .clk_axi     (clk_axi),
      .arst_axi    (arst_axi),
      .push_i      (buf_push[i]),
      .push_data_i (pkt_in_data_i),
      .pop_i       (buf_pop[i]),
      .head_o      (buf_head[i]),
      .full_o      (buf_full[i]),
      .empty_o     (buf_empty[i])
    );
  end

endmodule

`default_nettype wire

//--- source/vc_rd_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_noc_settings.svh"

interface vc_rd_if;
  // channel picked by the read side
  logic [$clog2(`AXI_NOC_NUM_VC)-1:0] sel_vc;
  // takes one word from that channel this cycle
  logic                               pop;
  // head word of the selected channel
  logic [`AXI_NOC_DATA_W-1:0]         head_data;
  // one bit per channel
  logic [`AXI_NOC_NUM_VC-1:0]         empty;

  modport rd_ctrl (output sel_vc, output pop, input head_data, input empty);
  modport buffers (input sel_vc, input pop, output head_data, output empty);
endinterface

`default_nettype wire

//--- source/ot_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ot_fifo
  import axi_noc_pkg::*;
#(
  parameter type item_t = flit_t,
  parameter int  DEPTH  = 4
) (
  input  logic  clk_axi,
  input  logic  arst_axi,
  input  logic  push_i,
  input  item_t push_data_i,
  input  logic  pop_i,
  output item_t head_o,
  output logic  full_o,
  output logic  empty_o
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // push ignored when full, pop ignored when empty
  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem[rd_ptr];

  // storage
  always_ff @(posedge clk_axi) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // pointers wrap at depth, count tracks fill
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/axi_noc_pkg.sv
`default_nettype none
`include "axi_noc_settings.svh"

package axi_noc_pkg;

  // burst encodings
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;

  // response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [$clog2(`AXI_NOC_NUM_VC)-1:0] vc_id_t;
  typedef logic [`AXI_NOC_DATA_W-1:0]          flit_t;

  // queued address request
  typedef struct packed {
    vc_id_t                   vc;
    logic [7:0]               len;
    logic [`AXI_NOC_ID_W-1:0] id;
    logic                     error;
  } ot_entry_t;

  // queued write response
  typedef struct packed {
    logic [`AXI_NOC_ID_W-1:0] id;
    logic                     error;
  } wr_resp_t;

  // aligned slot inside the window, channel below channel count
  function automatic logic win_hit(input logic [`AXI_NOC_ADDR_W-1:0] addr,
                                   input logic [`AXI_NOC_ADDR_W-1:0] base);
    logic [`AXI_NOC_ADDR_W-1:0] offs;
    offs = addr - base;
    return (addr >= base) && (offs[2:0] == 3'b000) &&
           ((offs >> 3) < `AXI_NOC_ADDR_W'(`AXI_NOC_NUM_VC));
  endfunction

  // slot index inside the window
  function automatic vc_id_t win_vc(input logic [`AXI_NOC_ADDR_W-1:0] addr,
                                    input logic [`AXI_NOC_ADDR_W-1:0] base);
    logic [`AXI_NOC_ADDR_W-1:0] offs;
    offs = addr - base;
    return offs[3 +: $bits(vc_id_t)];
  endfunction

endpackage

`default_nettype wire

//--- source/axi_noc_settings.svh
`ifndef AXI_NOC_SETTINGS_SVH
`define AXI_NOC_SETTINGS_SVH

// ************************************************************
// bus widths
// ************************************************************
`define AXI_NOC_DATA_W    32
`define AXI_NOC_ID_W      4
// only the low address bits are decoded
`define AXI_NOC_ADDR_W    16

// channels and queue depths
`define AXI_NOC_NUM_VC    2
`define AXI_NOC_OT_WR     4
`define AXI_NOC_OT_RD     4
`define AXI_NOC_RX_DEPTH  8

// window bases, one 8-byte slot per channel
`define AXI_NOC_WR_BASE   16'h1000
`define AXI_NOC_RD_BASE   16'h2000

`endif
